/* retire_core.f */
rtl/retire_core_pkg.sv
rtl/int_alu.sv
rtl/iterative_multiplier.sv
rtl/completion_bus.sv
rtl/register_file.sv
rtl/reorder_buffer.sv
rtl/retire_core.sv
sim/retire_core_properties.sv
sim/retire_core_tb.sv

/* Bender.yml */
package:
  name: retire_core

sources:
  - files:
      - rtl/retire_core_pkg.sv
      - rtl/int_alu.sv
      - rtl/iterative_multiplier.sv
      - rtl/completion_bus.sv
      - rtl/register_file.sv
      - rtl/reorder_buffer.sv
      - rtl/retire_core.sv
  - target: simulation
    files:
      - sim/retire_core_properties.sv
      - sim/retire_core_tb.sv

/* sim/retire_core_tb.sv */
`timescale 1ns/10ps

module retire_core_tb;

    import retire_core_pkg::*;

    localparam time clk_period   = 40ns;
    localparam int  reset_cycles = 10;
    // watchdog cycles allowed per table row
    localparam int  row_budget   = 30;
    localparam logic [15:0] lfsr_seed = 16'd65;

    logic                           clock;
    logic                           rst_n;
    logic                           dispatch_valid;
    opcode_e                        dispatch_op;
    logic [reg_addr_w-1:0]          dispatch_rd;
    logic [xlen-1:0]                dispatch_a;
    logic [xlen-1:0]                dispatch_b;
    logic                           dispatch_stall;
    logic                           commit_valid;
    logic [reg_addr_w-1:0]          commit_rd;
    logic [xlen-1:0]                commit_data;
    error_status_e                  error_status;
    logic [reg_count-1:0][xlen-1:0] regs_out;

    ////////////////////
    // stimulus table
    ////////////////////

    string                 tab_name [$];
    opcode_e               tab_op [$];
    logic [reg_addr_w-1:0] tab_rd [$];
    logic [xlen-1:0]       tab_a [$];
    logic [xlen-1:0]       tab_b [$];
    // bit 0 draws a from the lfsr, bit 1 draws b
    logic [1:0]            tab_rand [$];

    // expected commits, oldest first
    string                 exp_name [$];
    logic [reg_addr_w-1:0] exp_rd [$];
    logic [xlen-1:0]       exp_data [$];
    logic [xlen-1:0]       model_regs [reg_count];

    logic [15:0] lfsr;
    logic        stall_seen;
    logic        table_ready;
    // set once an illegal op is dispatched
    logic        retire_frozen;

    retire_core UUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_stall (dispatch_stall),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .error_status   (error_status),
        .regs_out       (regs_out)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    ////////////////////
    // random operands
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [xlen-1:0] rand_word();
        logic [xlen-1:0] w;
        w = '0;
        for (int i = 0; i < xlen; i++) begin
            w = {w[xlen-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic legal_op(opcode_e op);
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_sll, op_slt, op_mul: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] expected_result(opcode_e op, logic [xlen-1:0] a,
                                                        logic [xlen-1:0] b);
        logic [2*xlen-1:0] product;
        logic              less;
        product = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        // signs differ, so the negative one is smaller
        less    = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_slt:  return {{(xlen-1){1'b0}}, less};
            op_mul:  return product[xlen-1:0];
            default: return '0;
        endcase
    endfunction

    // nothing from an illegal op onward commits
    task automatic record_expected(string name, opcode_e op, logic [reg_addr_w-1:0] rd,
                                   logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic [xlen-1:0] value;
        if (!legal_op(op)) begin
            retire_frozen = 1'b1;
        end
        if (retire_frozen) begin
            return;
        end
        value = expected_result(op, a, b);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
        if (rd != '0) begin
            model_regs[rd] = value;
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_index(string name, logic [reg_addr_w-1:0] expected,
                               logic [reg_addr_w-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected r%0d actual r%0d", name, expected, actual));
        end
    endtask

    task automatic check_status(string name, error_status_e expected, error_status_e actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %s actual %s", name, expected.name(),
                                actual.name()));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // commits sampled mid cycle, popped in order
    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            if (exp_rd.size() == 0) begin
                abort_run($sformatf("commit to r%0d with nothing outstanding", commit_rd));
            end else begin
                check_index(exp_name[0], exp_rd[0], commit_rd);
                check_data(exp_name[0], exp_data[0], commit_data);
                void'(exp_name.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    ////////////////////
    // table and driver
    ////////////////////

    task automatic add_row(string name, opcode_e op, int rd, logic [xlen-1:0] a,
                           logic [xlen-1:0] b, logic [1:0] rnd);
        tab_name.push_back(name);
        tab_op.push_back(op);
        tab_rd.push_back(reg_addr_w'(rd));
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_rand.push_back(rnd);
    endtask

    task automatic build_table();
        add_row("alu_ops", op_add, 1, 32'd5, 32'd7, 2'b00);
        add_row("alu_ops", op_sub, 2, 32'd3, 32'd10, 2'b00);
        add_row("alu_ops", op_and, 3, 32'hf0f0_ff00, 32'h0ff0_0ff0, 2'b00);
        add_row("alu_ops", op_or, 4, 32'hf000_000f, 32'h0000_ff00, 2'b00);
        add_row("alu_ops", op_xor, 5, 32'haaaa_5555, 32'hffff_0000, 2'b00);
        // 36 masks down to a shift of 4
        add_row("alu_ops", op_sll, 6, 32'd1, 32'd36, 2'b00);
        add_row("alu_ops", op_sll, 7, 32'h8000_0001, 32'd31, 2'b00);
        add_row("alu_ops", op_slt, 8, 32'hffff_ffff, 32'd1, 2'b00);
        add_row("alu_ops", op_slt, 9, 32'd1, 32'hffff_ffff, 2'b00);
        add_row("alu_ops", op_slt, 10, '0, '0, 2'b11);
        add_row("alu_ops", op_add, 11, '0, '0, 2'b11);
        add_row("alu_ops", op_sub, 12, '0, 32'd5, 2'b01);
        // younger alu ops finish first
        add_row("mul_order", op_mul, 13, '0, '0, 2'b11);
        add_row("mul_order", op_add, 14, 32'd1, 32'd2, 2'b00);
        add_row("mul_order", op_xor, 15, '0, '0, 2'b11);
        add_row("mul_order", op_sub, 1, 32'd100, 32'd1, 2'b00);
        add_row("mul_order", op_mul, 2, 32'hffff_ffff, 32'hffff_ffff, 2'b00);
        add_row("mul_order", op_and, 3, '0, 32'h0000_ffff, 2'b01);
        add_row("backpressure", op_mul, 4, '0, '0, 2'b11);
        add_row("backpressure", op_mul, 5, '0, '0, 2'b11);
        add_row("backpressure", op_mul, 6, '0, '0, 2'b11);
        for (int k = 0; k < rob_size + 1; k++) begin
            add_row("backpressure", op_add, 7 + k, '0, xlen'(k), 2'b01);
        end
        add_row("reg_zero", op_add, 0, 32'd11, 32'd22, 2'b00);
        add_row("reg_zero", op_mul, 0, '0, '0, 2'b11);
        add_row("reg_zero", op_or, 0, '0, '0, 2'b11);
        add_row("reg_zero", op_add, 1, '0, '0, 2'b01);
        // the mul keeps an older entry in flight
        add_row("illegal", op_mul, 8, '0, '0, 2'b11);
        add_row("illegal", op_illegal, 9, 32'd1, 32'd1, 2'b00);
        // enters behind the illegal op and never retires
        add_row("illegal", op_add, 10, 32'd1, 32'd2, 2'b00);
    endtask

    // entered and left on a falling edge
    task automatic apply_row(int i);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = tab_rand[i][0] ? rand_word() : tab_a[i];
        b = tab_rand[i][1] ? rand_word() : tab_b[i];
        dispatch_op    = tab_op[i];
        dispatch_rd    = tab_rd[i];
        dispatch_a     = a;
        dispatch_b     = b;
        dispatch_valid = 1'b0;
        @(negedge clock);
        while (dispatch_stall) begin
            if (tab_name[i] == "backpressure") begin
                stall_seen = 1'b1;
            end
            @(negedge clock);
        end
        dispatch_valid = 1'b1;
        @(posedge clock);
        record_expected(tab_name[i], tab_op[i], tab_rd[i], a, b);
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    initial begin
        wait (table_ready);
        #(tab_op.size() * row_budget * clk_period);
        abort_run($sformatf("timeout with %0d commits still outstanding", exp_rd.size()));
    end

    initial begin
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = op_add;
        dispatch_rd    = '0;
        dispatch_a     = '0;
        dispatch_b     = '0;
        lfsr           = lfsr_seed;
        stall_seen     = 1'b0;
        retire_frozen  = 1'b0;
        for (int r = 0; r < reg_count; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_bit("reset_stall", 1'b0, dispatch_stall);
        check_bit("reset_commit", 1'b0, commit_valid);
        check_status("reset_status", no_error, error_status);
        for (int r = 0; r < reg_count; r++) begin
            check_data("reset_regs", '0, regs_out[r]);
        end
        for (int i = 0; i < tab_op.size(); i++) begin
            apply_row(i);
        end
        check_bit("backpressure_stall", 1'b1, stall_seen);
        // a later op stays parked at the inputs
        dispatch_op = op_add;
        dispatch_rd = 4'd7;
        dispatch_a  = 32'd1;
        dispatch_b  = 32'd2;
        while (error_status != illegal_inst) begin
            @(negedge clock);
        end
        check_bit("illegal_drain", 1'b1, exp_rd.size() == 0);
        repeat (rob_size) begin
            @(negedge clock);
            check_bit("illegal_stall", 1'b1, dispatch_stall);
        end
        check_status("illegal_status", illegal_inst, error_status);
        for (int r = 0; r < reg_count; r++) begin
            check_data("final_regs", model_regs[r], regs_out[r]);
        end
        check_data("reg_zero_final", '0, regs_out[0]);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* sim/retire_core_properties.sv */
`timescale 1ns/10ps

module retire_core_properties (
    input logic                                clock,
    input logic                                rst_n,
    input logic                                dispatch_stall,
    input logic                                alu_start,
    input logic                                mult_start,
    input logic                                commit_valid,
    input logic [retire_core_pkg::rob_tag_w:0] count,
    input retire_core_pkg::error_status_e      error_status
);

    import retire_core_pkg::*;

    ////////////////////
    // rob rules
    ////////////////////

    // retirement frozen by an illegal op
    no_commit_after_error: assert property (@(posedge clock) disable iff (!rst_n)
        (error_status == illegal_inst) |-> !commit_valid)
        else $error("commit pulse while error status is illegal_inst");

    count_bounded: assert property (@(posedge clock) disable iff (!rst_n)
        count <= (rob_tag_w+1)'(rob_size))
        else $error("rob entry count above rob_size");

    // one unit per dispatch
    one_start: assert property (@(posedge clock) disable iff (!rst_n)
        !(alu_start && mult_start))
        else $error("alu and multiplier started together");

    no_start_in_stall: assert property (@(posedge clock) disable iff (!rst_n)
        (alu_start || mult_start) |-> !dispatch_stall)
        else $error("unit started while dispatch stalled");

endmodule

bind reorder_buffer retire_core_properties u_properties (
    .clock          (clock),
    .rst_n          (rst_n),
    .dispatch_stall (dispatch_stall),
    .alu_start      (alu_start),
    .mult_start     (mult_start),
    .commit_valid   (commit_valid),
    .count          (count),
    .error_status   (error_status)
);

/* rtl/retire_core.sv */
`timescale 1ns/10ps

module retire_core (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic                                   dispatch_valid,
    input  retire_core_pkg::opcode_e               dispatch_op,
    input  logic [retire_core_pkg::reg_addr_w-1:0]   dispatch_rd,
    input  logic [retire_core_pkg::xlen-1:0]         dispatch_a,
    input  logic [retire_core_pkg::xlen-1:0]         dispatch_b,
    output logic                                   dispatch_stall,
    output logic                                   commit_valid,
    output logic [retire_core_pkg::reg_addr_w-1:0]   commit_rd,
    output logic [retire_core_pkg::xlen-1:0]         commit_data,
    output retire_core_pkg::error_status_e         error_status,
    output logic [retire_core_pkg::reg_count-1:0][retire_core_pkg::xlen-1:0] regs_out
);

    import retire_core_pkg::*;

    ////////////////////
    // internal wires
    ////////////////////

    logic                 alu_start;
    logic                 mult_start;
    logic [rob_tag_w-1:0] dispatch_tag;
    // unit outputs
    logic                 alu_done;
    logic [xlen-1:0]      alu_result;
    logic [rob_tag_w-1:0] alu_tag;
    logic                 mult_busy;
    logic                 mult_done;
    logic [xlen-1:0]      mult_result;
    logic [rob_tag_w-1:0] mult_tag;
    // completion
    logic                 alu_slot_full;
    logic                 mult_slot_full;
    logic                 cdb_valid;
    logic [rob_tag_w-1:0] cdb_tag;
    logic [xlen-1:0]      cdb_value;

    reorder_buffer u_rob (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_stall (dispatch_stall),
        .alu_start      (alu_start),
        .mult_start     (mult_start),
        .dispatch_tag   (dispatch_tag),
        .alu_slot_full  (alu_slot_full),
        .mult_slot_full (mult_slot_full),
        .mult_busy      (mult_busy),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .error_status   (error_status)
    );

    ////////////////////
    // functional units
    ////////////////////

    // operands arrive resolved, fed to both units
    int_alu u_alu (
        .start      (alu_start),
        .op         (dispatch_op),
        .a          (dispatch_a),
        .b          (dispatch_b),
        .tag_in     (dispatch_tag),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .alu_tag    (alu_tag)
    );

    iterative_multiplier u_mult (
        .clock       (clock),
        .rst_n       (rst_n),
        .start       (mult_start),
        .a           (dispatch_a),
        .b           (dispatch_b),
        .tag_in      (dispatch_tag),
        .mult_busy   (mult_busy),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .mult_tag    (mult_tag)
    );

    completion_bus u_cdb (
        .clock          (clock),
        .rst_n          (rst_n),
        .alu_done       (alu_done),
        .alu_result     (alu_result),
        .alu_tag        (alu_tag),
        .mult_done      (mult_done),
        .mult_result    (mult_result),
        .mult_tag       (mult_tag),
        .alu_slot_full  (alu_slot_full),
        .mult_slot_full (mult_slot_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    // commit target
    register_file u_rf (
        .clock        (clock),
        .rst_n        (rst_n),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .regs_out     (regs_out)
    );

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                                 clock,
    input  logic                                 rst_n,
    // dispatch side
    input  logic                                 dispatch_valid,
    input  retire_core_pkg::opcode_e             dispatch_op,
    input  logic [retire_core_pkg::reg_addr_w-1:0] dispatch_rd,
    output logic                                 dispatch_stall,
    output logic                                 alu_start,
    output logic                                 mult_start,
    output logic [retire_core_pkg::rob_tag_w-1:0]  dispatch_tag,
    // unit occupancy
    input  logic                                 alu_slot_full,
    input  logic                                 mult_slot_full,
    input  logic                                 mult_busy,
    // common data bus
    input  logic                                 cdb_valid,
    input  logic [retire_core_pkg::rob_tag_w-1:0]  cdb_tag,
    input  logic [retire_core_pkg::xlen-1:0]       cdb_value,
    // retirement
    output logic                                 commit_valid,
    output logic [retire_core_pkg::reg_addr_w-1:0] commit_rd,
    output logic [retire_core_pkg::xlen-1:0]       commit_data,
    output retire_core_pkg::error_status_e       error_status
);

    import retire_core_pkg::*;

    ////////////////////
    // entry storage
    ////////////////////

    logic [rob_size-1:0]   ent_valid;
    logic [rob_size-1:0]   ent_done;
    logic [rob_size-1:0]   ent_illegal;
    logic [reg_addr_w-1:0] ent_rd [rob_size];
    logic [xlen-1:0]       ent_value [rob_size];

    logic [rob_tag_w-1:0]  head;
    logic [rob_tag_w-1:0]  tail;
    // one extra bit so a full buffer is visible
    logic [rob_tag_w:0]    count;

    logic is_alu;
    logic is_mul;
    logic is_illegal;
    logic accept;
    logic head_ready;

    ////////////////////
    // dispatch routing
    ////////////////////

    // decode target unit from opcode
    always_comb begin
        is_alu     = 1'b0;
        is_mul     = 1'b0;
        is_illegal = 1'b0;
        case (dispatch_op)
            op_add, op_sub, op_and, op_or, op_xor, op_sll, op_slt: is_alu = 1'b1;
            op_mul:  is_mul = 1'b1;
            // op_illegal and every unlisted code
            default: is_illegal = 1'b1;
        endcase
    end

    // stall level from occupancy, target unit state and error status
    assign dispatch_stall = (count == (rob_tag_w+1)'(rob_size))
                          || (is_alu && alu_slot_full)
                          || (is_mul && (mult_busy || mult_slot_full))
                          || (error_status == illegal_inst);

    assign accept       = dispatch_valid && !dispatch_stall;
    // units start in the accepting cycle
    assign alu_start    = accept && is_alu;
    assign mult_start   = accept && is_mul;
    assign dispatch_tag = tail;

    ////////////////////
    // in-order retire
    ////////////////////

    // head is done and retirement still allowed
    assign head_ready   = ent_valid[head] && ent_done[head] && (error_status == no_error);
    // illegal head gives no commit pulse
    assign commit_valid = head_ready && !ent_illegal[head];
    assign commit_rd    = ent_rd[head];
    assign commit_data  = ent_value[head];

    // pointers, occupancy, status bits
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            ent_done     <= '0;
            error_status <= no_error;
        end else begin
            if (accept) begin
                ent_valid[tail] <= 1'b1;
                // illegal ops finish at dispatch
                ent_done[tail]  <= is_illegal;
                tail            <= tail + 1'b1;
            end
            // result broadcast, tagged writeback
            if (cdb_valid) begin
                ent_done[cdb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            // illegal at head freezes retirement until reset
            if (head_ready && ent_illegal[head]) begin
                error_status <= illegal_inst;
            end
            case ({accept, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload fields
    always_ff @(posedge clock) begin
        if (accept) begin
            ent_rd[tail]      <= dispatch_rd;
            ent_illegal[tail] <= is_illegal;
        end
        if (cdb_valid) begin
            ent_value[cdb_tag] <= cdb_value;
        end
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic                                   commit_valid,
    input  logic [retire_core_pkg::reg_addr_w-1:0]   commit_rd,
    input  logic [retire_core_pkg::xlen-1:0]         commit_data,
    output logic [retire_core_pkg::reg_count-1:0][retire_core_pkg::xlen-1:0] regs_out
);

    import retire_core_pkg::*;

    ////////////////////
    // architectural state
    ////////////////////

    // register 0 is never written, stays zero
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            regs_out <= '0;
        end else if (commit_valid && (commit_rd != '0)) begin
            regs_out[commit_rd] <= commit_data;
        end
    end

endmodule

/* rtl/completion_bus.sv */
`timescale 1ns/10ps

module completion_bus (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                alu_done,
    input  logic [retire_core_pkg::xlen-1:0]      alu_result,
    input  logic [retire_core_pkg::rob_tag_w-1:0] alu_tag,
    input  logic                                mult_done,
    input  logic [retire_core_pkg::xlen-1:0]      mult_result,
    input  logic [retire_core_pkg::rob_tag_w-1:0] mult_tag,
    output logic                                alu_slot_full,
    output logic                                mult_slot_full,
    output logic                                cdb_valid,
    output logic [retire_core_pkg::rob_tag_w-1:0] cdb_tag,
    output logic [retire_core_pkg::xlen-1:0]      cdb_value
);

    import retire_core_pkg::*;

    // unit inputs gathered by slot index
    logic [fu_mult:fu_alu] unit_done;
    logic [xlen-1:0]       unit_result [fu_alu:fu_mult];
    logic [rob_tag_w-1:0]  unit_tag [fu_alu:fu_mult];

    ////////////////////
    // holding slots
    ////////////////////

    logic [fu_mult:fu_alu] slot_ready;
    logic [xlen-1:0]       slot_value [fu_alu:fu_mult];
    logic [rob_tag_w-1:0]  slot_tag [fu_alu:fu_mult];
    fu_e                   sel;

    assign unit_done[fu_alu]    = alu_done;
    assign unit_done[fu_mult]   = mult_done;
    assign unit_result[fu_alu]  = alu_result;
    assign unit_result[fu_mult] = mult_result;
    assign unit_tag[fu_alu]     = alu_tag;
    assign unit_tag[fu_mult]    = mult_tag;

    assign alu_slot_full  = slot_ready[fu_alu];
    assign mult_slot_full = slot_ready[fu_mult];

    // fixed priority, multiplier first
    assign sel       = slot_ready[fu_mult] ? fu_mult : fu_alu;
    assign cdb_valid = |slot_ready;
    assign cdb_tag   = slot_tag[sel];
    assign cdb_value = slot_value[sel];

    // a new result beats the clear from broadcast
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_ready <= '0;
        end else begin
            for (int u = fu_alu; u <= fu_mult; u++) begin
                if (unit_done[u]) begin
                    slot_ready[u] <= 1'b1;
                end else if (cdb_valid && (sel == fu_e'(u))) begin
                    slot_ready[u] <= 1'b0;
                end
            end
        end
    end

    // result and tag captured on done
    always_ff @(posedge clock) begin
        for (int u = fu_alu; u <= fu_mult; u++) begin
            if (unit_done[u]) begin
                slot_value[u] <= unit_result[u];
                slot_tag[u]   <= unit_tag[u];
            end
        end
    end

endmodule

/* rtl/iterative_multiplier.sv */
`timescale 1ns/10ps

module iterative_multiplier (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [retire_core_pkg::xlen-1:0]      a,
    input  logic [retire_core_pkg::xlen-1:0]      b,
    input  logic [retire_core_pkg::rob_tag_w-1:0] tag_in,
    output logic                                mult_busy,
    output logic                                mult_done,
    output logic [retire_core_pkg::xlen-1:0]      mult_result,
    output logic [retire_core_pkg::rob_tag_w-1:0] mult_tag
);

    import retire_core_pkg::*;

    logic [xlen-1:0]               mcand;
    logic [xlen-1:0]               mplier;
    logic [xlen-1:0]               acc;
    logic [xlen-1:0]               partial;
    logic [$clog2(mult_steps)-1:0] step;

    ////////////////////
    // shift-add step
    ////////////////////

    // low byte of the multiplier times the shifted multiplicand
    assign partial = mcand * xlen'(mplier[7:0]);

    // last step result goes straight to the slot
    assign mult_result = acc + partial;
    assign mult_done   = mult_busy && (step == mult_steps - 1);

    // busy and step count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mult_busy <= 1'b0;
            step      <= '0;
        end else if (start) begin
            mult_busy <= 1'b1;
            step      <= '0;
        end else if (mult_done) begin
            mult_busy <= 1'b0;
        end else if (mult_busy) begin
            step <= step + 1'b1;
        end
    end

    // operands and accumulator
    always_ff @(posedge clock) begin
        if (start) begin
            mcand    <= a;
            mplier   <= b;
            acc      <= '0;
            mult_tag <= tag_in;
        end else if (mult_busy) begin
            acc    <= mult_result;
            // bits above xlen fall off, low word only
            mcand  <= mcand << 8;
            mplier <= mplier >> 8;
        end
    end

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/10ps

module int_alu (
    input  logic                                start,
    input  retire_core_pkg::opcode_e            op,
    input  logic [retire_core_pkg::xlen-1:0]      a,
    input  logic [retire_core_pkg::xlen-1:0]      b,
    input  logic [retire_core_pkg::rob_tag_w-1:0] tag_in,
    output logic                                alu_done,
    output logic [retire_core_pkg::xlen-1:0]      alu_result,
    output logic [retire_core_pkg::rob_tag_w-1:0] alu_tag
);

    import retire_core_pkg::*;

    ////////////////////
    // single cycle
    ////////////////////

    // done in the start cycle, the slot captures at the edge
    assign alu_done = start;

    // add, sub, logic ops, sll and signed slt
    always_comb begin
        alu_result = alu_compute(op, a, b);
    end

    // tag goes back with the result
    assign alu_tag = tag_in;

endmodule

/* rtl/retire_core_pkg.sv */
package retire_core_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int xlen       = 32;
    localparam int reg_count  = 16;
    localparam int reg_addr_w = 4;
    localparam int rob_size   = 8;
    localparam int rob_tag_w  = 3;
    // 8 multiplier bits per step
    localparam int mult_steps = 4;

    ////////////////////
    // encodings
    ////////////////////

    // unlisted codes decode as illegal
    typedef enum logic [3:0] {
        op_add     = 4'h0,
        op_sub     = 4'h1,
        op_and     = 4'h2,
        op_or      = 4'h3,
        op_xor     = 4'h4,
        op_sll     = 4'h5,
        op_slt     = 4'h6,
        op_mul     = 4'h7,
        op_illegal = 4'hf
    } opcode_e;

    // slot index for completion holding
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_e;

    typedef enum logic {
        no_error     = 1'b0,
        illegal_inst = 1'b1
    } error_status_e;

    // reference result for one op
    function automatic logic [xlen-1:0] alu_compute(
        input opcode_e         op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b
    );
        case (op)
            op_add:  alu_compute = a + b;
            op_sub:  alu_compute = a - b;
            op_and:  alu_compute = a & b;
            op_or:   alu_compute = a | b;
            op_xor:  alu_compute = a ^ b;
            // shift amount is the low 5 bits only
            op_sll:  alu_compute = a << b[4:0];
            op_slt:  alu_compute = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            // low word of the product
            op_mul:  alu_compute = a * b;
            default: alu_compute = '0;
        endcase
    endfunction

endpackage
